//--- src/rram_ctrl_defines.svh
`ifndef RRAM_CTRL_DEFINES_SVH
`define RRAM_CTRL_DEFINES_SVH

// Array geometry
`define RRAM_ARRAY_SIZE    16
`define RRAM_ADDR_W        4
`define RRAM_INSTR_W       32
`define RRAM_SENSE_W       16

// Queue depths
`define RRAM_INSTR_DEPTH   16
`define RRAM_RESULT_DEPTH  8

// Phase lengths in clock cycles
`define RRAM_WRITE_CYCLES  4
`define RRAM_SENSE_CYCLES  2

// Instruction fields
`define RRAM_OP_MSB        31
`define RRAM_OP_LSB        28
`define RRAM_WR_COL_LSB    0
`define RRAM_WR_ROW_LSB    4
`define RRAM_WR_DATA_BIT   8 // 1 = SET, 0 = RESET
`define RRAM_RD_HALF_BIT   0 // 1 = columns 15..8
`define RRAM_RD_ROW_LSB    1

`endif

//--- src/rram_ctrl_pkg.sv
package rram_ctrl_pkg;

	typedef enum logic [3:0] {
		OP_IDLE   = 4'd0,
		OP_WRITE  = 4'd1,
		OP_READ   = 4'd2,
		OP_MAC    = 4'd3, // Decoded as no-op
		OP_CONF_T = 4'd4, // Decoded as no-op
		OP_CONF_V = 4'd5  // Decoded as no-op
	} opcode_e;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_WRITE,
		ST_PRECHARGE,
		ST_SENSE,
		ST_RECOVER
	} seq_state_e;

	// Line code set selected on a driver load
	typedef enum logic [1:0] {
		LINE_REST,
		LINE_SET,
		LINE_RESET,
		LINE_READ
	} line_mode_e;

endpackage

//--- src/instr_fifo.sv
`include "rram_ctrl_defines.svh"

module instr_fifo (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     wr,
	input  logic [`RRAM_INSTR_W-1:0] data,
	input  logic                     pop,
	output logic [`RRAM_INSTR_W-1:0] word,
	output logic                     empty,
	output logic                     full
);

	localparam int DEPTH = `RRAM_INSTR_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`RRAM_INSTR_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [CNT_W-1:0]         count;
	logic                     do_wr;
	logic                     do_rd;

	assign do_wr = wr && !full;  // Host writes into a full queue are dropped
	assign do_rd = pop && !empty;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

	////////////////////////////////////////
	// Pointers and occupancy

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	////////////////////////////////////////
	// Storage and popped word

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= data;
		if (do_rd)
			word <= mem[rd_ptr]; // Held until the next pop
	end

endmodule

//--- src/rram_sequencer.sv
`include "rram_ctrl_defines.svh"

module rram_sequencer (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       run,
	input  logic [`RRAM_INSTR_W-1:0]   instr_word,
	input  logic                       instr_empty,
	input  logic                       result_full,
	output logic                       pop,
	output logic                       busy,
	output logic                       drive_load,
	output rram_ctrl_pkg::line_mode_e  drive_mode,
	output logic [`RRAM_ADDR_W-1:0]    row,
	output logic [`RRAM_ADDR_W-1:0]    col,
	output logic                       col_half,
	output logic                       en_wl,
	output logic                       en_bl,
	output logic                       en_sl,
	output logic                       pre,
	output logic                       saen,
	output logic                       capture
);

	import rram_ctrl_pkg::*;

	localparam int PHASE_MAX = (`RRAM_WRITE_CYCLES > `RRAM_SENSE_CYCLES) ?
		`RRAM_WRITE_CYCLES : `RRAM_SENSE_CYCLES;
	localparam int CNT_W = $clog2(PHASE_MAX + 1);

	seq_state_e       state;
	seq_state_e       next_state;
	opcode_e          op;
	logic [CNT_W-1:0] cnt;
	logic             write_last;
	logic             sense_last;

	////////////////////////////////////////
	// Decode

	assign op = opcode_e'(instr_word[`RRAM_OP_MSB:`RRAM_OP_LSB]);

	// Read and write keep the row in different fields
	assign row = (op == OP_READ) ? instr_word[`RRAM_RD_ROW_LSB +: `RRAM_ADDR_W] :
		instr_word[`RRAM_WR_ROW_LSB +: `RRAM_ADDR_W];
	assign col      = instr_word[`RRAM_WR_COL_LSB +: `RRAM_ADDR_W];
	assign col_half = instr_word[`RRAM_RD_HALF_BIT];

	assign write_last = (state == ST_WRITE) && (cnt == CNT_W'(`RRAM_WRITE_CYCLES - 1));
	assign sense_last = (state == ST_SENSE) && (cnt == CNT_W'(`RRAM_SENSE_CYCLES - 1));

	assign pop     = (state == ST_FETCH);
	assign busy    = (state != ST_IDLE);
	assign capture = sense_last; // csa lands in the result FIFO at this edge

	////////////////////////////////////////
	// Next state and driver loads

	always_comb begin
		next_state = state;
		drive_load = 1'b0;
		drive_mode = LINE_REST;
		case (state)
			ST_IDLE:
				if (run && !instr_empty)
					next_state = ST_FETCH;
			ST_FETCH:
				next_state = ST_DECODE;
			ST_DECODE: begin
				case (op)
					OP_WRITE: begin
						drive_load = 1'b1;
						drive_mode = instr_word[`RRAM_WR_DATA_BIT] ? LINE_SET : LINE_RESET;
						next_state = ST_WRITE;
					end
					OP_READ: begin
						if (!result_full) begin // Stall here until a result slot frees
							drive_load = 1'b1;
							drive_mode = LINE_READ;
							next_state = ST_PRECHARGE;
						end
					end
					default: begin // Idle, MAC, pulse config and unknown codes
						drive_load = 1'b1;
						next_state = ST_RECOVER;
					end
				endcase
			end
			ST_WRITE:
				if (write_last) begin
					drive_load = 1'b1;
					next_state = ST_RECOVER;
				end
			ST_PRECHARGE:
				next_state = ST_SENSE;
			ST_SENSE:
				if (sense_last) begin
					drive_load = 1'b1;
					next_state = ST_RECOVER;
				end
			ST_RECOVER:
				next_state = ST_IDLE;
			default:
				next_state = ST_IDLE;
		endcase
	end

	////////////////////////////////////////
	// State, phase counter and array controls

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ST_IDLE;
			cnt   <= '0;
			en_wl <= 1'b0;
			en_bl <= 1'b0;
			en_sl <= 1'b0;
			pre   <= 1'b1;
			saen  <= 1'b0;
		end else begin
			state <= next_state;
			if (next_state != state)
				cnt <= '0;
			else if (state == ST_WRITE || state == ST_SENSE)
				cnt <= cnt + 1'b1;
			// Controls follow the state they are registered for
			en_wl <= (next_state == ST_WRITE) || (next_state == ST_SENSE);
			en_bl <= (next_state == ST_WRITE) || (next_state == ST_SENSE);
			en_sl <= (next_state == ST_WRITE);
			pre   <= (next_state != ST_PRECHARGE);
			saen  <= (next_state == ST_SENSE);
		end
	end

endmodule

//--- src/line_driver.sv
`include "rram_ctrl_defines.svh"

module line_driver (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        load,
	input  rram_ctrl_pkg::line_mode_e   mode,
	input  logic [`RRAM_ADDR_W-1:0]     row,
	input  logic [`RRAM_ADDR_W-1:0]     col,
	input  logic                        col_half,
	output logic [`RRAM_ARRAY_SIZE-1:0] bl_in0,
	output logic [`RRAM_ARRAY_SIZE-1:0] bl_in1,
	output logic [`RRAM_ARRAY_SIZE-1:0] sl_in0,
	output logic [`RRAM_ARRAY_SIZE-1:0] sl_in1,
	output logic [`RRAM_ARRAY_SIZE-1:0] wl_in0,
	output logic [`RRAM_ARRAY_SIZE-1:0] wl_in1,
	output logic                        col_select
);

	import rram_ctrl_pkg::*;

	localparam int N = `RRAM_ARRAY_SIZE;

	logic [N-1:0] nxt_bl0;
	logic [N-1:0] nxt_bl1;
	logic [N-1:0] nxt_sl0;
	logic [N-1:0] nxt_sl1;
	logic [N-1:0] nxt_wl0;
	logic [N-1:0] nxt_wl1;
	logic         nxt_col_sel;

	////////////////////////////////////////
	// Code set for the requested mode

	always_comb begin
		nxt_bl0     = '1; // 11 is the rest code on every line
		nxt_bl1     = '1;
		nxt_sl0     = '1;
		nxt_sl1     = '1;
		nxt_wl0     = '1;
		nxt_wl1     = '1;
		nxt_col_sel = 1'b0;
		for (int i = 0; i < N; i++) begin
			case (mode)
				LINE_SET, LINE_RESET: begin
					if (`RRAM_ADDR_W'(i) == row) begin
						nxt_wl0[i] = 1'b0; // Write voltage on the addressed WL
						nxt_wl1[i] = 1'b1;
					end
					if (`RRAM_ADDR_W'(i) == col) begin
						if (mode == LINE_SET) begin
							nxt_bl0[i] = 1'b0;
							nxt_bl1[i] = 1'b0;
						end else begin
							nxt_sl0[i] = 1'b0;
							nxt_sl1[i] = 1'b1;
						end
					end
				end
				LINE_READ: begin
					if (`RRAM_ADDR_W'(i) == row) begin
						nxt_wl0[i] = 1'b0;
						nxt_wl1[i] = 1'b0;
					end
					if ((i >= N / 2) == col_half)
						nxt_bl0[i] = 1'b0; // 01 on the sensed half
					nxt_col_sel = col_half;
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Held codes

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bl_in0     <= '1;
			bl_in1     <= '1;
			sl_in0     <= '1;
			sl_in1     <= '1;
			wl_in0     <= '1;
			wl_in1     <= '1;
			col_select <= 1'b0;
		end else if (load) begin
			bl_in0     <= nxt_bl0;
			bl_in1     <= nxt_bl1;
			sl_in0     <= nxt_sl0;
			sl_in1     <= nxt_sl1;
			wl_in0     <= nxt_wl0;
			wl_in1     <= nxt_wl1;
			col_select <= nxt_col_sel;
		end
	end

endmodule

//--- src/read_capture.sv
`include "rram_ctrl_defines.svh"

module read_capture (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     capture,
	input  logic [`RRAM_SENSE_W-1:0] csa,
	input  logic                     rd,
	output logic [`RRAM_SENSE_W-1:0] data,
	output logic                     empty,
	output logic                     full
);

	localparam int DEPTH = `RRAM_RESULT_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`RRAM_SENSE_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [CNT_W-1:0]         count;
	logic                     do_wr;
	logic                     do_rd;

	assign do_wr = capture && !full;
	assign do_rd = rd && !empty; // Pops on an empty FIFO are ignored

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));
	assign data  = mem[rd_ptr]; // Head word, valid while not empty

	////////////////////////////////////////
	// Pointers and occupancy

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// Sense word sampled at the capture edge
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= csa;
	end

endmodule

//--- src/rram_ctrl.sv
`include "rram_ctrl_defines.svh"

module rram_ctrl (
	input  logic                        clk,
	input  logic                        rst,
	// Host side
	input  logic                        instr_wr,
	input  logic [`RRAM_INSTR_W-1:0]    instr_data,
	output logic                        instr_full,
	output logic                        instr_empty,
	input  logic                        run,
	input  logic                        result_rd,
	output logic [`RRAM_SENSE_W-1:0]    result_data,
	output logic                        result_empty,
	output logic                        busy,
	// Array side
	output logic [`RRAM_ARRAY_SIZE-1:0] bl_in0,
	output logic [`RRAM_ARRAY_SIZE-1:0] bl_in1,
	output logic [`RRAM_ARRAY_SIZE-1:0] sl_in0,
	output logic [`RRAM_ARRAY_SIZE-1:0] sl_in1,
	output logic [`RRAM_ARRAY_SIZE-1:0] wl_in0,
	output logic [`RRAM_ARRAY_SIZE-1:0] wl_in1,
	output logic                        en_wl,
	output logic                        en_bl,
	output logic                        en_sl,
	output logic                        pre,
	output logic                        saen,
	output logic                        col_select,
	input  logic [`RRAM_SENSE_W-1:0]    csa
);

	import rram_ctrl_pkg::*;

	logic [`RRAM_INSTR_W-1:0] instr_word;
	logic                     pop;
	logic                     result_full;
	logic                     capture;
	logic                     drive_load;
	line_mode_e               drive_mode;
	logic [`RRAM_ADDR_W-1:0]  row;
	logic [`RRAM_ADDR_W-1:0]  col;
	logic                     col_half;

	instr_fifo u_instr_fifo (.clk(clk), .rst(rst), .wr(instr_wr), .data(instr_data),
		.pop(pop), .word(instr_word), .empty(instr_empty), .full(instr_full));

	rram_sequencer u_rram_sequencer (.clk(clk), .rst(rst), .run(run),
		.instr_word(instr_word), .instr_empty(instr_empty), .result_full(result_full),
		.pop(pop), .busy(busy), .drive_load(drive_load), .drive_mode(drive_mode),
		.row(row), .col(col), .col_half(col_half), .en_wl(en_wl), .en_bl(en_bl),
		.en_sl(en_sl), .pre(pre), .saen(saen), .capture(capture));

	line_driver u_line_driver (.clk(clk), .rst(rst), .load(drive_load), .mode(drive_mode),
		.row(row), .col(col), .col_half(col_half), .bl_in0(bl_in0), .bl_in1(bl_in1),
		.sl_in0(sl_in0), .sl_in1(sl_in1), .wl_in0(wl_in0), .wl_in1(wl_in1),
		.col_select(col_select));

	read_capture u_read_capture (.clk(clk), .rst(rst), .capture(capture), .csa(csa),
		.rd(result_rd), .data(result_data), .empty(result_empty), .full(result_full));

endmodule

//--- dv/rram_ctrl_clk.sv
module rram_ctrl_clk #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk; // First rising edge at half a period
	end

endmodule

//--- dv/rram_ctrl_props.sv
`include "rram_ctrl_defines.svh"

module rram_ctrl_props (
	input logic                        clk,
	input logic                        rst,
	input rram_ctrl_pkg::seq_state_e   state,
	input logic                        en_wl,
	input logic                        en_bl,
	input logic                        en_sl,
	input logic                        saen,
	input logic                        capture
);

	import rram_ctrl_pkg::*;

	int fail_count = 0;

	////////////////////////////////////////
	// Read phases

	precharge_then_sense: assert property (@(posedge clk) disable iff (!rst)
		(state == ST_PRECHARGE) |=> (state == ST_SENSE))
	else begin
		$error("precharge did not hand over to sense after one cycle");
		fail_count++;
	end

	no_sense_with_sl: assert property (@(posedge clk) disable iff (!rst)
		!(saen && en_sl))
	else begin
		$error("sense amplifier enabled while the source lines were driven");
		fail_count++;
	end

	capture_in_sense: assert property (@(posedge clk) disable iff (!rst)
		capture |-> (state == ST_SENSE))
	else begin
		$error("capture pulsed outside the sense phase");
		fail_count++;
	end

	////////////////////////////////////////
	// Write pulse length

	write_pulse_len: assert property (@(posedge clk) disable iff (!rst)
		$rose(en_sl) |-> (en_sl && en_wl && en_bl) [*`RRAM_WRITE_CYCLES] ##1 !en_sl)
	else begin
		$error("write enables did not last the write pulse length");
		fail_count++;
	end

endmodule

//--- dv/rram_ctrl_tb.sv
`include "rram_ctrl_defines.svh"

module rram_ctrl_tb;

	import rram_ctrl_pkg::*;

	localparam int N            = `RRAM_ARRAY_SIZE;
	localparam int KIND_SET     = 1;
	localparam int KIND_RESET   = 2;
	localparam int KIND_READ    = 3;
	localparam int BUSY_TIMEOUT = 40;

	logic                     clk;
	logic                     rst;
	logic                     instr_wr;
	logic [`RRAM_INSTR_W-1:0] instr_data;
	logic                     instr_full;
	logic                     instr_empty;
	logic                     run;
	logic                     result_rd;
	logic [`RRAM_SENSE_W-1:0] result_data;
	logic                     result_empty;
	logic                     busy;
	logic [N-1:0]             bl_in0;
	logic [N-1:0]             bl_in1;
	logic [N-1:0]             sl_in0;
	logic [N-1:0]             sl_in1;
	logic [N-1:0]             wl_in0;
	logic [N-1:0]             wl_in1;
	logic                     en_wl;
	logic                     en_bl;
	logic                     en_sl;
	logic                     pre;
	logic                     saen;
	logic                     col_select;
	logic [`RRAM_SENSE_W-1:0] csa;
	logic [6*N-1:0]           codes;

	// Stimulus table, one entry per instruction
	string       t_name [$];
	opcode_e     t_op   [$];
	int          t_row  [$];
	int          t_ch   [$]; // Column for writes, half for reads
	bit          t_data [$];
	bit          t_hold [$]; // Pushed with run low first
	logic [15:0] t_exp  [$];

	logic [N-1:0] cells     [N]; // Array model
	logic [N-1:0] exp_cells [N];

	int cur_idx;
	bit cur_by_sense;
	int senses;
	int sense_base;
	int write_pulses;
	int precharges;
	bit saen_prev;
	bit en_sl_prev;
	bit pre_prev;
	int main_count;
	int bp_base;

	rram_ctrl_clk #(.PERIOD(100)) clk0 (.clk(clk));

	rram_ctrl dut0 (.*);

	bind rram_sequencer rram_ctrl_props props0 (.clk(clk), .rst(rst), .state(state),
		.en_wl(en_wl), .en_bl(en_bl), .en_sl(en_sl), .saen(saen),
		.capture(capture));

	assign codes = {bl_in0, bl_in1, sl_in0, sl_in1, wl_in0, wl_in1};

	////////////////////////////////////////
	// Array model

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int r = 0; r < N; r++)
				cells[r] <= '0;
		end else if (en_bl && en_sl) begin
			for (int r = 0; r < N; r++) begin
				for (int c = 0; c < N; c++) begin
					if (!wl_in0[r] && wl_in1[r]) begin
						if (!bl_in0[c] && !bl_in1[c])
							cells[r][c] <= 1'b1; // SET
						else if (!sl_in0[c] && sl_in1[c])
							cells[r][c] <= 1'b0; // RESET
					end
				end
			end
		end
	end

	always_comb begin
		csa = '0;
		if (saen) begin
			for (int r = 0; r < N; r++) begin
				for (int c = 0; c < N; c++) begin
					if (!wl_in0[r] && !wl_in1[r] && !bl_in0[c] && bl_in1[c])
						csa[c % 8] = cells[r][c]; // Sensed half lands in the low byte
				end
			end
		end
	end

	////////////////////////////////////////
	// Reporting and reference

	task automatic fail_stop();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		$display("MISMATCH %s expected %0h actual %0h", name, exp, act);
		fail_stop();
	endtask

	task automatic report_failure(input string what);
		$display("ERROR %s", what);
		fail_stop();
	endtask

	task automatic check_value(input string name, input logic [127:0] exp,
		input logic [127:0] act);
		assert (act === exp) else report_mismatch(name, exp, act);
	endtask

	// Expected {bl0, bl1, sl0, sl1, wl0, wl1}, all 11 at rest
	function automatic logic [6*N-1:0] line_codes(input int kind, input int row, input int ch);
		logic [N-1:0] bl0;
		logic [N-1:0] bl1;
		logic [N-1:0] sl0;
		logic [N-1:0] sl1;
		logic [N-1:0] wl0;
		logic [N-1:0] wl1;
		bl0 = '1;
		bl1 = '1;
		sl0 = '1;
		sl1 = '1;
		wl0 = '1;
		wl1 = '1;
		for (int i = 0; i < N; i++) begin
			if (kind == KIND_SET || kind == KIND_RESET) begin
				if (i == row)
					wl0[i] = 1'b0;
				if (kind == KIND_SET && i == ch) begin
					bl0[i] = 1'b0;
					bl1[i] = 1'b0;
				end
				if (kind == KIND_RESET && i == ch)
					sl0[i] = 1'b0;
			end else if (kind == KIND_READ) begin
				if (i == row) begin
					wl0[i] = 1'b0;
					wl1[i] = 1'b0;
				end
				if ((i / 8) == ch)
					bl0[i] = 1'b0;
			end
		end
		return {bl0, bl1, sl0, sl1, wl0, wl1};
	endfunction

	task automatic add_entry(input string name, input opcode_e op, input int row,
		input int ch, input bit data, input bit hold);
		logic [15:0] exp_word;
		exp_word = '0;
		if (op == OP_WRITE)
			exp_cells[row][ch] = data;
		else if (op == OP_READ)
			exp_word = {8'h00, exp_cells[row][ch * 8 +: 8]};
		t_name.push_back(name);
		t_op.push_back(op);
		t_row.push_back(row);
		t_ch.push_back(ch);
		t_data.push_back(data);
		t_hold.push_back(hold);
		t_exp.push_back(exp_word);
	endtask

	function automatic logic [`RRAM_INSTR_W-1:0] encode(input int i);
		logic [`RRAM_INSTR_W-1:0] w;
		w = '0;
		w[`RRAM_OP_MSB:`RRAM_OP_LSB] = t_op[i];
		if (t_op[i] == OP_READ) begin
			w[`RRAM_RD_ROW_LSB +: `RRAM_ADDR_W] = `RRAM_ADDR_W'(t_row[i]);
			w[`RRAM_RD_HALF_BIT] = (t_ch[i] != 0);
		end else begin
			// Ignored opcodes carry a payload too
			w[`RRAM_WR_ROW_LSB +: `RRAM_ADDR_W] = `RRAM_ADDR_W'(t_row[i]);
			w[`RRAM_WR_COL_LSB +: `RRAM_ADDR_W] = `RRAM_ADDR_W'(t_ch[i]);
			w[`RRAM_WR_DATA_BIT] = t_data[i];
		end
		return w;
	endfunction

	////////////////////////////////////////
	// Cycle monitor and drivers

	task automatic check_cycle();
		int r;
		int p;
		if (en_sl && !en_sl_prev)
			write_pulses++;
		if (saen && !saen_prev)
			senses++;
		if (!pre && pre_prev)
			precharges++;
		en_sl_prev = en_sl;
		saen_prev  = saen;
		pre_prev   = pre;
		r = cur_by_sense ? cur_idx + senses - sense_base - 1 : cur_idx;
		p = cur_by_sense ? r + 1 : r; // Precharge comes before its sense
		if (en_sl)
			check_value({t_name[r], " write lines"},
				{line_codes(t_data[r] ? KIND_SET : KIND_RESET, t_row[r], t_ch[r]), 4'b1110},
				{codes, pre, en_wl, en_bl, saen});
		if (saen)
			check_value({t_name[r], " read lines"},
				{line_codes(KIND_READ, t_row[r], t_ch[r]), t_ch[r] != 0, 4'b1110},
				{codes, col_select, pre, en_wl, en_bl, en_sl});
		if (!pre)
			check_value({t_name[p], " precharge levels"}, 4'b0000,
				{en_wl, en_bl, en_sl, saen});
		if (!cur_by_sense && t_op[r] != OP_WRITE && t_op[r] != OP_READ)
			check_value({t_name[r], " rest lines"}, {{(6 * N){1'b1}}, 4'b0000},
				{codes, en_wl, en_bl, en_sl, saen});
	endtask

	task automatic drive_edge();
		@(posedge clk);
		#10;
	endtask

	task automatic step();
		@(negedge clk); // Outputs settled mid cycle
		check_cycle();
	endtask

	task automatic wait_busy(input logic level, input string name);
		int n;
		n = 0;
		while (busy !== level) begin
			if (n == BUSY_TIMEOUT)
				report_failure($sformatf("timeout waiting for busy=%0b in %s", level, name));
			step();
			n++;
		end
	endtask

	task automatic push_instr(input int i);
		drive_edge();
		instr_wr   = 1'b1;
		instr_data = encode(i);
		if (t_hold[i])
			run = 1'b0;
		step();
	endtask

	task automatic end_push();
		drive_edge();
		instr_wr = 1'b0;
		step();
	endtask

	task automatic pop_result(input string name, input logic [15:0] exp);
		check_value({name, " result_empty"}, 0, result_empty);
		check_value(name, exp, result_data);
		drive_edge();
		result_rd = 1'b1;
		step();
		drive_edge();
		result_rd = 1'b0;
		step();
	endtask

	////////////////////////////////////////
	// Tests

	task automatic build_table();
		add_entry("set_r3_c5", OP_WRITE, 3, 5, 1, 0);
		add_entry("set_r3_c10", OP_WRITE, 3, 10, 1, 0);
		add_entry("set_r3_c0", OP_WRITE, 3, 0, 1, 0);
		add_entry("read_r3_lo", OP_READ, 3, 0, 0, 0);
		add_entry("read_r3_hi", OP_READ, 3, 1, 0, 0);
		add_entry("set_r12_c15", OP_WRITE, 12, 15, 1, 0);
		add_entry("set_r12_c8", OP_WRITE, 12, 8, 1, 0);
		add_entry("read_r12_hi", OP_READ, 12, 1, 0, 0);
		add_entry("reset_r3_c5", OP_WRITE, 3, 5, 0, 0);
		add_entry("read_r3_lo_after_reset", OP_READ, 3, 0, 0, 0);
		add_entry("idle_op", OP_IDLE, 0, 0, 0, 0);
		add_entry("mac_op", OP_MAC, 5, 3, 1, 0);
		add_entry("conf_t_run_low", OP_CONF_T, 7, 2, 1, 1);
		add_entry("conf_v_op", OP_CONF_V, 9, 9, 0, 0);
		add_entry("set_r0_c7", OP_WRITE, 0, 7, 1, 0);
		add_entry("read_r0_lo", OP_READ, 0, 0, 0, 0);
		add_entry("read_r15_hi", OP_READ, 15, 1, 0, 0);
		main_count = t_name.size();
		bp_base    = main_count;
		add_entry("bp_r3_lo", OP_READ, 3, 0, 0, 0);
		add_entry("bp_r3_hi", OP_READ, 3, 1, 0, 0);
		add_entry("bp_r12_hi", OP_READ, 12, 1, 0, 0);
		add_entry("bp_r0_lo", OP_READ, 0, 0, 0, 0);
		add_entry("bp_r12_lo", OP_READ, 12, 0, 0, 0);
		add_entry("bp_r15_lo", OP_READ, 15, 0, 0, 0);
		add_entry("bp_r3_lo_b", OP_READ, 3, 0, 0, 0);
		add_entry("bp_r0_hi", OP_READ, 0, 1, 0, 0);
		add_entry("bp_r12_hi_b", OP_READ, 12, 1, 0, 0);
	endtask

	task automatic run_entry(input int i);
		int s0;
		int w0;
		int p0;
		cur_idx      = i;
		cur_by_sense = 1'b0;
		s0 = senses;
		w0 = write_pulses;
		p0 = precharges;
		push_instr(i);
		end_push();
		if (t_hold[i]) begin
			repeat (8) begin
				step();
				check_value({t_name[i], " busy, instr_empty and instr_full"}, 3'b000,
					{busy, instr_empty, instr_full});
			end
			drive_edge();
			run = 1'b1;
			step();
		end
		wait_busy(1'b1, t_name[i]);
		wait_busy(1'b0, t_name[i]);
		check_value({t_name[i], " write pulses"}, t_op[i] == OP_WRITE, write_pulses - w0);
		check_value({t_name[i], " sense phases"}, t_op[i] == OP_READ, senses - s0);
		check_value({t_name[i], " precharge phases"}, t_op[i] == OP_READ, precharges - p0);
		if (t_op[i] == OP_READ)
			pop_result(t_name[i], t_exp[i]);
		check_value({t_name[i], " result_empty"}, 1, result_empty);
	endtask

	task automatic back_pressure();
		int n;
		int p0;
		cur_idx      = bp_base;
		cur_by_sense = 1'b1;
		sense_base   = senses;
		p0           = precharges;
		for (int k = 0; k < 9; k++)
			push_instr(bp_base + k);
		end_push();
		n = 0;
		while (senses - sense_base < 8 || saen) begin
			if (n == 200)
				report_failure("timeout waiting for eight reads to fill the result FIFO");
			step();
			n++;
		end
		repeat (20) begin
			step();
			check_value("bp_stall saen", 0, saen); // Ninth read held in decode
		end
		check_value("bp_stall busy", 1, busy);
		pop_result(t_name[bp_base], t_exp[bp_base]);
		n = 0;
		while (senses - sense_base < 9 || busy) begin
			if (n == 100)
				report_failure("timeout waiting for the stalled read to finish");
			step();
			n++;
		end
		check_value("bp precharge phases", 9, precharges - p0);
		for (int k = 1; k < 9; k++)
			pop_result(t_name[bp_base + k], t_exp[bp_base + k]);
		check_value("bp_drained result_empty", 1, result_empty);
	endtask

	initial begin
		rst          = 1'b0;
		instr_wr     = 1'b0;
		instr_data   = '0;
		run          = 1'b0;
		result_rd    = 1'b0;
		senses       = 0;
		sense_base   = 0;
		write_pulses = 0;
		precharges   = 0;
		saen_prev    = 1'b0;
		en_sl_prev   = 1'b0;
		pre_prev     = 1'b1;
		cur_idx      = 0;
		cur_by_sense = 1'b0;
		for (int r = 0; r < N; r++)
			exp_cells[r] = '0;
		build_table();
		repeat (16) @(posedge clk);
		#10;
		rst = 1'b1;
		@(negedge clk);
		check_value("reset_values", {{(6 * N){1'b1}}, 9'b000010110},
			{codes, en_wl, en_bl, en_sl, saen, pre, busy, result_empty, instr_empty,
			instr_full});
		drive_edge();
		run = 1'b1;
		for (int i = 0; i < main_count; i++)
			run_entry(i);
		back_pressure();
		if (dut0.u_rram_sequencer.props0.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			report_failure("bound sequencer assertions failed during the run");
		end
	end

endmodule

//--- rram_ctrl.f
+incdir+src
src/rram_ctrl_pkg.sv
src/instr_fifo.sv
src/rram_sequencer.sv
src/line_driver.sv
src/read_capture.sv
src/rram_ctrl.sv
dv/rram_ctrl_clk.sv
dv/rram_ctrl_props.sv
dv/rram_ctrl_tb.sv
